// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_temp_sensor
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
hdl/onewire_pkg.sv
hdl/apb_regs_pkg.sv
hdl/onewire_sequencer.sv
hdl/result_buffer.sv
hdl/apb_result_reader.sv
hdl/temp_sensor_top.sv
tb/onewire_slave_model.sv
tb/tb_temp_sensor.sv

// ==== hdl/apb_regs_pkg.sv ====
// ***********************************************************
// APB register map: request record, offsets, data window
// geometry and the status word layout
// ***********************************************************
package apb_regs_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  localparam logic [11:0] CTRL_OFS   = 12'h000; // bit 0 run
  localparam logic [11:0] STATUS_OFS = 12'h004;
  localparam logic [11:0] DATA_BASE  = 12'h100; // frame byte window

  // one result byte per 32 bit word
  localparam int          DATA_STRIDE = 4;
  localparam logic [11:0] DATA_WINDOW = 12'h100; // decoded span of the window

  localparam int CTRL_RUN_BIT = 0;

  typedef struct packed {
    logic [14:0] reserved;
    logic        running;     // mirrors CTRL run
    logic [15:0] frame_count; // completed frames, wraps
  } status_t;

endpackage

// ==== hdl/apb_result_reader.sv ====
// ***********************************************************
// APB slave for run control, status and the frame data window
// ***********************************************************
`timescale 1ns/1ps

module apb_result_reader (
  input  logic                   clk,
  input  logic                   rst,
  input  apb_regs_pkg::apb_req_t req,
  input  logic [7:0]             rd_data,
  input  logic [15:0]            frame_count,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [4:0]             rd_addr,
  output logic                   run
);

  logic        setup;
  logic        is_ctrl;
  logic        is_status;
  logic        is_data;
  logic [11:0] data_ofs;
  logic [11:0] data_idx;
  logic        acc_err;
  logic        data_pend;  // wait state while the buffer reads

  apb_regs_pkg::status_t status;

  assign setup     = req.psel && !req.penable;
  assign is_ctrl   = (req.paddr == apb_regs_pkg::CTRL_OFS);
  assign is_status = (req.paddr == apb_regs_pkg::STATUS_OFS);
  assign data_ofs  = req.paddr - apb_regs_pkg::DATA_BASE;
  assign is_data   = (req.paddr >= apb_regs_pkg::DATA_BASE) &&
                     (data_ofs < apb_regs_pkg::DATA_WINDOW);
  assign data_idx  = data_ofs / 12'(apb_regs_pkg::DATA_STRIDE);
  assign rd_addr   = data_idx[4:0];  // paddr stable from setup on

  // only CTRL takes writes, data index stops at the frame end
  assign acc_err = req.pwrite ? !is_ctrl
                              : !(is_ctrl || is_status ||
                                  (is_data && data_idx < 12'(onewire_pkg::FRAME_BYTES)));

  assign status = '{reserved: '0, running: run, frame_count: frame_count};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pready    <= 1'b0;
      pslverr   <= 1'b0;
      data_pend <= 1'b0;
      run       <= 1'b0;
    end else begin
      pready    <= 1'b0;
      pslverr   <= 1'b0;
      data_pend <= 1'b0;
      if (data_pend) begin
        pready <= 1'b1;          // second access cycle
      end else if (setup) begin
        if (!acc_err && !req.pwrite && is_data) begin
          data_pend <= 1'b1;
        end else begin
          pready  <= 1'b1;       // first access cycle
          pslverr <= acc_err;
          if (req.pwrite && is_ctrl)
            run <= req.pwdata[apb_regs_pkg::CTRL_RUN_BIT];
        end
      end
    end
  end

  // read data capture
  always_ff @(posedge clk) begin
    if (data_pend)
      prdata <= {24'h0, rd_data};
    else if (setup && !req.pwrite)
      prdata <= is_status ? status : (32'(run) << apb_regs_pkg::CTRL_RUN_BIT);
  end

  a_pready_access: assert property (@(posedge clk) disable iff (rst)
    pready |-> (req.psel && req.penable));

endmodule

// ==== hdl/onewire_pkg.sv ====
// ***********************************************************
// 1-Wire protocol package: step kinds, command bytes,
// poll script contents, slot timing and the byte-write record
// ***********************************************************
package onewire_pkg;

  // one script step per byte slot
  typedef enum logic [3:0] {
    CMD_NONE, // read slot, shifts out all ones
    CMD_RST,  // reset pulse, bus held low
    CMD_SIT,  // presence window, bus released
    CMD_SKP,  // skip ROM
    CMD_RDS,  // read scratchpad
    CMD_RDR,  // read ROM
    CMD_CVT,  // start conversion
    CMD_DLY   // conversion wait, no byte stored
  } cmd_e;

  localparam int SLOT_TICKS  = 16; // ticks per bit slot
  localparam int SAMPLE_TICK = 3;  // master sample point in the slot
  localparam int FRAME_BYTES = 31; // stored bytes per poll pass

  localparam logic [7:0] OW_SKIP_ROM  = 8'hcc;
  localparam logic [7:0] OW_READ_SCR  = 8'hbe;
  localparam logic [7:0] OW_READ_ROM  = 8'h33;
  localparam logic [7:0] OW_CONVERT   = 8'h44;
  localparam logic [7:0] OW_READ_FILL = 8'hff; // lets the device drive zeros

  typedef struct packed {
    logic       valid;
    logic [4:0] addr;
    logic [7:0] data;
    logic       last;  // marks byte FRAME_BYTES-1
  } byte_wr_t;

  // poll script, one entry per byte slot
  function automatic cmd_e script_cmd(input logic [4:0] addr);
    case (addr)
      5'd0, 5'd16, 5'd27: script_cmd = CMD_RST;
      5'd1, 5'd17, 5'd28: script_cmd = CMD_SIT;
      5'd2, 5'd29:        script_cmd = CMD_SKP;
      5'd3:               script_cmd = CMD_RDS; // 4..12 scratchpad, 13..15 idle
      5'd18:              script_cmd = CMD_RDR; // 19..26 serial number
      5'd30:              script_cmd = CMD_CVT;
      5'd31:              script_cmd = CMD_DLY;
      default:            script_cmd = CMD_NONE;
    endcase
  endfunction

  function automatic logic [7:0] cmd_byte(input cmd_e cmd);
    case (cmd)
      CMD_SKP: cmd_byte = OW_SKIP_ROM;
      CMD_RDS: cmd_byte = OW_READ_SCR;
      CMD_RDR: cmd_byte = OW_READ_ROM;
      CMD_CVT: cmd_byte = OW_CONVERT;
      default: cmd_byte = OW_READ_FILL; // rst/sit/dly ignore it
    endcase
  endfunction

endpackage

// ==== hdl/onewire_sequencer.sv ====
// ***********************************************************
// 1-Wire poll sequencer: steps the fixed script, times the
// bit slots, drives the bus and ships each sampled byte
// ***********************************************************
`timescale 1ns/1ps

module onewire_sequencer #(
  parameter int TICK_DIV  = 256,   // clocks per tick
  parameter int DLY_TICKS = 19200  // conversion wait in ticks
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 owire_in,
  output logic                 drive,
  output onewire_pkg::byte_wr_t wr
);

  logic [15:0] div_cnt;
  logic        tick;
  logic [15:0] slot_cnt;  // tick within slot, or within the delay step
  logic [2:0]  bit_idx;
  logic [4:0]  addr;      // script address == frame byte index
  logic [1:0]  owire_sync;
  logic [7:0]  shreg;     // lsb first, as on the wire

  onewire_pkg::cmd_e cur_cmd;
  logic [7:0]        tx_byte;  // byte shifted out by this step
  logic              tx_bit;
  logic              is_dly;
  logic              slot_last;
  logic              drv_next;

  // tick divider
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= (div_cnt == 16'(TICK_DIV - 1));
      if (div_cnt == 16'(TICK_DIV - 1))
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 16'd1;
    end
  end

  // script rom lookup
  assign cur_cmd = onewire_pkg::script_cmd(addr);
  assign tx_byte = onewire_pkg::cmd_byte(cur_cmd);
  assign tx_bit  = tx_byte[bit_idx];
  assign is_dly  = (cur_cmd == onewire_pkg::CMD_DLY);

  assign slot_last = is_dly ? (slot_cnt == 16'(DLY_TICKS - 1))
                            : (slot_cnt == 16'(onewire_pkg::SLOT_TICKS - 1));

  // slot, bit and byte stepping
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt <= '0;
      bit_idx  <= '0;
      addr     <= '0;
    end else if (tick) begin
      if (!run) begin           // parked at script start
        slot_cnt <= '0;
        bit_idx  <= '0;
        addr     <= '0;
      end else if (slot_last) begin
        slot_cnt <= '0;
        if (is_dly) begin       // wrap to the first reset
          bit_idx <= '0;
          addr    <= '0;
        end else begin
          bit_idx <= bit_idx + 3'd1;
          if (bit_idx == 3'd7)
            addr <= addr + 5'd1;  // 30 -> 31 enters the delay
        end
      end else begin
        slot_cnt <= slot_cnt + 16'd1;
      end
    end
  end

  // bus drive per slot
  always_comb begin
    case (cur_cmd)
      onewire_pkg::CMD_RST: drv_next = 1'b1;  // whole byte low
      onewire_pkg::CMD_SIT,
      onewire_pkg::CMD_DLY: drv_next = 1'b0;  // released
      default:
        // short pulse for a 1, hold through tick 14 for a 0
        drv_next = (slot_cnt == '0) ||
                   (!tx_bit && slot_cnt != 16'(onewire_pkg::SLOT_TICKS - 1));
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      drive <= 1'b0;
    else
      drive <= run && drv_next;  // let go as soon as run drops
  end

  // bus input sync, async pin
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      owire_sync <= 2'b11;  // idle bus reads high
    else
      owire_sync <= {owire_sync[0], owire_in};
  end

  // sample shift register
  always_ff @(posedge clk) begin
    if (tick && run && !is_dly && slot_cnt == 16'(onewire_pkg::SAMPLE_TICK))
      shreg <= {owire_sync[1], shreg[7:1]};
  end

  // one write per finished byte slot
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr <= '0;
    end else begin
      wr.valid <= tick && run && slot_last && !is_dly && bit_idx == 3'd7;
      wr.addr  <= addr;
      wr.data  <= shreg;
      wr.last  <= (addr == 5'(onewire_pkg::FRAME_BYTES - 1));
    end
  end

  // conversion wait keeps the bus free for the parasitic supply
  a_dly_released: assert property (@(posedge clk) disable iff (rst)
    is_dly |-> !drive);

  a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
    wr.valid |=> !wr.valid);

endmodule

// ==== hdl/result_buffer.sv ====
// ***********************************************************
// two bank frame store, swaps banks on each completed frame
// and counts frames
// ***********************************************************
`timescale 1ns/1ps

module result_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  onewire_pkg::byte_wr_t wr,
  input  logic [4:0]            rd_addr,
  output logic [7:0]            rd_data,
  output logic [15:0]           frame_count
);

  logic [7:0] mem [0:63];  // {bank, byte}
  logic       fill_sel;    // bank being written
  logic       have_frame;  // read bank holds a full frame

  always_ff @(posedge clk) begin
    if (wr.valid)
      mem[{fill_sel, wr.addr}] <= wr.data;
    // zeros until the first frame lands
    rd_data <= have_frame ? mem[{~fill_sel, rd_addr}] : 8'h00;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_sel    <= 1'b0;
      have_frame  <= 1'b0;
      frame_count <= '0;
    end else if (wr.valid && wr.last) begin
      fill_sel    <= ~fill_sel;  // last byte still goes to the old bank
      have_frame  <= 1'b1;
      frame_count <= frame_count + 16'd1;
    end
  end

  a_wr_in_frame: assert property (@(posedge clk) disable iff (rst)
    wr.valid |-> (wr.addr < 5'(onewire_pkg::FRAME_BYTES)));

endmodule

// ==== hdl/temp_sensor_top.sv ====
// ***********************************************************
// temperature sensor poller top: 1-Wire sequencer, frame
// buffer and APB reader
// ***********************************************************
`timescale 1ns/1ps

module temp_sensor_top #(
  parameter int TICK_DIV  = 256,
  parameter int DLY_TICKS = 19200
) (
  input  logic                   clk,
  input  logic                   rst,
  input  apb_regs_pkg::apb_req_t apb,
  input  logic                   owire_in,  // bus level, high when released
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   drive      // high pulls the bus low
);

  onewire_pkg::byte_wr_t wr;
  logic [4:0]            rd_addr;
  logic [7:0]            rd_data;
  logic [15:0]           frame_count;
  logic                  run;

  onewire_sequencer #(
    .TICK_DIV (TICK_DIV),
    .DLY_TICKS(DLY_TICKS)
  ) u_seq (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .owire_in(owire_in),
    .drive   (drive),
    .wr      (wr)
  );

  result_buffer u_buf (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_count(frame_count)
  );

  apb_result_reader u_apb (
    .clk        (clk),
    .rst        (rst),
    .req        (apb),
    .rd_data    (rd_data),
    .frame_count(frame_count),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .rd_addr    (rd_addr),
    .run        (run)
  );

endmodule

// ==== tb/onewire_slave_model.sv ====
// ***********************************************************
// behavioral 1-Wire device: presence pulse after reset and
// read slot answers from loaded scratchpad and ROM bytes
// ***********************************************************
`timescale 1ns/1ps

module onewire_slave_model #(
  parameter int TICK_DIV = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        present,        // device on the bus
  input  logic [71:0] scratch_bytes,  // byte 0 in the low bits
  input  logic [63:0] rom_bytes,
  input  logic        drive,          // master pull-down
  output logic        owire_in
);

  localparam int SLOT_CLKS = onewire_pkg::SLOT_TICKS * TICK_DIV;
  localparam int HOLD_CLKS = (onewire_pkg::SAMPLE_TICK + 2) * TICK_DIV;

  logic       drive_q;
  int         low_len;   // clocks of the current master low pulse
  int         pull_cnt;  // clocks left on our own pull-down
  logic       reading;   // answering read slots
  logic       rd_rom;
  int         rd_len;
  int         bit_cnt;
  int         byte_cnt;
  logic [7:0] rx_byte;
  logic [7:0] tx_byte;

  assign tx_byte = rd_rom ? rom_bytes[byte_cnt * 8 +: 8]
                          : scratch_bytes[byte_cnt * 8 +: 8];
  // wired-and of both pull-downs
  assign owire_in = !drive && !(present && pull_cnt != 0);

  always @(posedge clk or posedge rst) begin
    logic [7:0] rx_next;
    if (rst) begin
      drive_q  <= 1'b0;
      low_len  <= 0;
      pull_cnt <= 0;
      reading  <= 1'b0;
      rd_rom   <= 1'b0;
      rd_len   <= 0;
      bit_cnt  <= 0;
      byte_cnt <= 0;
      rx_byte  <= 8'h00;
    end else begin
      rx_next = {(low_len < SLOT_CLKS / 2), rx_byte[7:1]};  // short low is a 1, lsb first
      drive_q <= drive;
      if (pull_cnt != 0)
        pull_cnt <= pull_cnt - 1;
      if (drive && !drive_q) begin  // slot start
        low_len <= 1;
        if (reading && !tx_byte[bit_cnt])
          pull_cnt <= HOLD_CLKS;  // hold past the master sample point
      end else if (drive) begin
        low_len <= low_len + 1;
      end
      if (!drive && drive_q) begin
        if (low_len > 2 * SLOT_CLKS) begin
          // reset pulse over, presence in the first slot
          pull_cnt <= SLOT_CLKS;
          reading  <= 1'b0;
          bit_cnt  <= 0;
        end else if (reading) begin
          bit_cnt <= (bit_cnt + 1) % 8;
          if (bit_cnt == 7) begin
            byte_cnt <= byte_cnt + 1;
            if (byte_cnt == rd_len - 1)
              reading <= 1'b0;  // back to listening
          end
        end else begin
          rx_byte <= rx_next;
          bit_cnt <= (bit_cnt + 1) % 8;
          if (bit_cnt == 7 && (rx_next == onewire_pkg::OW_READ_SCR ||
                               rx_next == onewire_pkg::OW_READ_ROM)) begin
            reading  <= 1'b1;
            rd_rom   <= (rx_next == onewire_pkg::OW_READ_ROM);
            rd_len   <= (rx_next == onewire_pkg::OW_READ_ROM) ? 8 : 9;
            byte_cnt <= 0;
          end
        end
      end
    end
  end

endmodule

// ==== tb/tb_temp_sensor.sv ====
// ***********************************************************
// testbench for the temperature sensor poller: APB access,
// 1-Wire device model and golden frame compare
// ***********************************************************
`timescale 1ns/1ps

module tb_temp_sensor;

  localparam int TICK_DIV    = 4;
  localparam int DLY_TICKS   = 64;
  localparam int APB_TIMEOUT = 8;     // access cycles before giving up
  localparam int FRAME_POLLS = 6000;  // status polls, about three frames
  localparam int ROM_BASE    = 9;     // golden layout
  localparam int PRESENT_MAP = 17;
  localparam int ABSENT_MAP  = 48;

  logic                   clk = 1'b0;
  logic                   rst;
  apb_regs_pkg::apb_req_t apb;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   drive;
  logic                   owire_in;
  logic                   present;
  logic [71:0]            scratch_bytes;
  logic [63:0]            rom_bytes;
  logic [7:0]             golden [0:78];

  always #4 clk = ~clk;

  temp_sensor_top #(
    .TICK_DIV (TICK_DIV),
    .DLY_TICKS(DLY_TICKS)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .apb     (apb),
    .owire_in(owire_in),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .drive   (drive)
  );

  onewire_slave_model #(.TICK_DIV(TICK_DIV)) u_dev (
    .clk          (clk),
    .rst          (rst),
    .present      (present),
    .scratch_bytes(scratch_bytes),
    .rom_bytes    (rom_bytes),
    .drive        (drive),
    .owire_in     (owire_in)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_status(input apb_regs_pkg::status_t got,
                              input apb_regs_pkg::status_t exp);
    if (got !== exp)
      report_failure($sformatf("error: status got %08h expected %08h", got, exp));
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      report_failure($sformatf("error: %s got %02h expected %02h", name, got, exp));
  endtask

  task automatic check_resp(input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("error: pslverr got %h expected %h", got, exp));
  endtask

  task automatic check_waits(input int got, input int exp);
    if (got != exp)
      report_failure($sformatf("error: pready wait states got %0h expected %0h", got, exp));
  endtask

  function automatic apb_regs_pkg::status_t make_status(input logic       run_bit,
                                                        input logic [15:0] count);
    make_status = '{reserved: '0, running: run_bit, frame_count: count};
  endfunction

  // one APB transfer, setup then access until pready
  task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    int exp_waits;
    waits = 0;
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb.penable <= 1'b1;
    @(posedge clk);
    while (!pready) begin
      if (waits == APB_TIMEOUT)
        report_failure("APB transfer timed out waiting for pready");
      waits++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    apb <= '0;  // back to idle
    // frame window reads wait one cycle for the buffer
    exp_waits = (!write && addr >= apb_regs_pkg::DATA_BASE &&
                 addr < apb_regs_pkg::DATA_BASE +
                        12'(onewire_pkg::FRAME_BYTES * apb_regs_pkg::DATA_STRIDE)) ? 1 : 0;
    check_waits(waits, exp_waits);
  endtask

  task automatic read_status(output apb_regs_pkg::status_t st);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, apb_regs_pkg::STATUS_OFS, '0, rdata, err);
    check_resp(err, 1'b0);
    st = rdata;
  endtask

  task automatic wait_frames(input logic [15:0] target, output apb_regs_pkg::status_t st);
    int polls;
    polls = 0;
    read_status(st);
    while (st.frame_count < target) begin
      if (polls == FRAME_POLLS)
        report_failure("frame counter never reached the expected count");
      polls++;
      repeat (8) @(posedge clk);
      read_status(st);
    end
  endtask

  task automatic watch_drive_idle(input int clocks);
    for (int i = 0; i < clocks; i++) begin
      @(posedge clk);
      check_byte("drive", {7'h00, drive}, 8'h00);
    end
  endtask

  // all 31 window bytes against one golden map
  task automatic check_frame(input int map_base);
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < onewire_pkg::FRAME_BYTES; i++) begin
      apb_xfer(1'b0, apb_regs_pkg::DATA_BASE + 12'(i * apb_regs_pkg::DATA_STRIDE), '0,
               rdata, err);
      check_resp(err, 1'b0);
      check_byte($sformatf("prdata[%0d]", i), rdata[7:0], golden[map_base + i]);
    end
  endtask

  initial begin
    logic [31:0]           rdata;
    logic                  err;
    apb_regs_pkg::status_t st;
    logic [15:0]           base_count;

    rst     = 1'b1;
    apb     = '0;
    present = 1'b1;
    $readmemh("tb/temp_golden.hex", golden);
    for (int i = 0; i < 9; i++)
      scratch_bytes[i * 8 +: 8] = golden[i];
    for (int i = 0; i < 8; i++)
      rom_bytes[i * 8 +: 8] = golden[ROM_BASE + i];
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // idle after reset
    apb_xfer(1'b0, apb_regs_pkg::CTRL_OFS, '0, rdata, err);
    check_resp(err, 1'b0);
    check_byte("ctrl", rdata[7:0], 8'h00);
    read_status(st);
    check_status(st, make_status(1'b0, 16'd0));
    watch_drive_idle(200);

    // device present, first two frames
    apb_xfer(1'b1, apb_regs_pkg::CTRL_OFS, 32'h1, rdata, err);
    check_resp(err, 1'b0);
    wait_frames(16'd2, st);
    check_frame(PRESENT_MAP);

    // device gone, frame in flight is mixed
    present <= 1'b0;
    read_status(st);
    base_count = st.frame_count + 16'd2;
    wait_frames(base_count, st);
    check_frame(ABSENT_MAP);

    // device back while the next frame fills the other bank
    present <= 1'b1;
    repeat (6000) @(posedge clk);
    read_status(st);
    check_status(st, make_status(1'b1, base_count));
    check_frame(ABSENT_MAP);
    read_status(st);
    check_status(st, make_status(1'b1, base_count));

    // halt polling
    apb_xfer(1'b1, apb_regs_pkg::CTRL_OFS, 32'h0, rdata, err);
    check_resp(err, 1'b0);
    read_status(st);
    check_status(st, make_status(1'b0, base_count));
    watch_drive_idle(20000);
    read_status(st);
    check_status(st, make_status(1'b0, base_count));

    // accesses outside the map
    apb_xfer(1'b0, 12'h008, '0, rdata, err);
    check_resp(err, 1'b1);
    apb_xfer(1'b0, apb_regs_pkg::DATA_BASE +
             12'(onewire_pkg::FRAME_BYTES * apb_regs_pkg::DATA_STRIDE), '0, rdata, err);
    check_resp(err, 1'b1);
    apb_xfer(1'b1, apb_regs_pkg::STATUS_OFS, 32'h1, rdata, err);
    check_resp(err, 1'b1);
    apb_xfer(1'b0, apb_regs_pkg::CTRL_OFS, '0, rdata, err);
    check_resp(err, 1'b0);
    check_byte("ctrl", rdata[7:0], 8'h00);  // status write left run clear

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== tb/temp_golden.hex ====
// one hex byte per entry, in order: 9 scratchpad bytes, 8 ROM bytes,
// then the 31-byte frame map for a present device and for an absent device
91 01 4b 46 7f ff 0f 10 25
28 a2 3c 6e 0b 00 00 e1
// present device map
00 fe cc be
91 01 4b 46 7f ff 0f 10 25 ff ff ff
00 fe 33
28 a2 3c 6e 0b 00 00 e1
00 fe cc 44
// absent device map
00 ff cc be
ff ff ff ff ff ff ff ff ff ff ff ff
00 ff 33
ff ff ff ff ff ff ff ff
00 ff cc 44
